// File: dtlb_pkg.sv
/*
  dtlb shared definitions
  sizes, field widths and typedefs for the data TLB and its testbench.
  replacement ages start at the way number, so way k begins at age k
  (INIT_AGE_OF_WAY); age 0 is most recently used, age WAYS-1 is the victim.
*/
package dtlb_pkg;

  localparam int WAYS       = 4;
  localparam int SETS       = 16;
  localparam int READ_PORTS = 2;

  // field widths
  localparam int SET_BITS  = 4;
  localparam int TAG_BITS  = 16;
  localparam int VPN_BITS  = SET_BITS + TAG_BITS;
  localparam int ASID_BITS = 8;
  localparam int PPN_BITS  = 20;
  localparam int PERM_BITS = 4;
  localparam int WAY_BITS  = 2;
  localparam int AGE_BITS  = 2;

  // vpn: set index in the low bits, tag above it
  typedef logic [VPN_BITS-1:0]  vpn_t;
  typedef logic [SET_BITS-1:0]  set_t;
  typedef logic [TAG_BITS-1:0]  tag_t;
  typedef logic [ASID_BITS-1:0] asid_t;
  typedef logic [PPN_BITS-1:0]  ppn_t;
  typedef logic [PERM_BITS-1:0] perm_t;
  typedef logic [WAY_BITS-1:0]  way_t;
  typedef logic [AGE_BITS-1:0]  age_t;

  // starting age per way, loaded by the init sweep
  localparam age_t [WAYS-1:0] INIT_AGE_OF_WAY = {2'd3, 2'd2, 2'd1, 2'd0};

  typedef enum logic {
    INIT,
    RUN
  } ctrl_state_t;

endpackage

// File: dtlb_way.sv
/*
  dtlb_way
  entry storage for one way of the TLB, one entry per set.
  compares every lookup port and the maintenance address against the
  entry of the indexed set; writes a new or an invalid entry on wr_en.
*/
`timescale 1ns/10ps
module dtlb_way (
  input  logic                                              clk,
  input  logic                                              wr_en,
  input  dtlb_pkg::set_t                                    wr_set,
  input  logic                                              wr_clear,
  input  dtlb_pkg::tag_t                                    wr_tag,
  input  dtlb_pkg::asid_t                                   wr_asid,
  input  logic                                              wr_global,
  input  dtlb_pkg::ppn_t                                    wr_ppn,
  input  dtlb_pkg::perm_t                                   wr_perm,
  input  dtlb_pkg::vpn_t  [dtlb_pkg::READ_PORTS-1:0]        lookup_vpn,
  input  dtlb_pkg::asid_t [dtlb_pkg::READ_PORTS-1:0]        lookup_asid,
  input  dtlb_pkg::vpn_t                                    maint_vpn,
  input  dtlb_pkg::asid_t                                   maint_asid,
  output logic            [dtlb_pkg::READ_PORTS-1:0]        hit,
  output dtlb_pkg::ppn_t  [dtlb_pkg::READ_PORTS-1:0]        hit_ppn,
  output dtlb_pkg::perm_t [dtlb_pkg::READ_PORTS-1:0]        hit_perm,
  output logic                                              maint_hit
);

  logic            valid_q  [dtlb_pkg::SETS];
  logic            global_q [dtlb_pkg::SETS];
  dtlb_pkg::asid_t asid_q   [dtlb_pkg::SETS];
  dtlb_pkg::tag_t  tag_q    [dtlb_pkg::SETS];
  dtlb_pkg::ppn_t  ppn_q    [dtlb_pkg::SETS];
  dtlb_pkg::perm_t perm_q   [dtlb_pkg::SETS];

  dtlb_pkg::set_t  mt_set;
  dtlb_pkg::tag_t  mt_tag;

  // valid, same tag, and global or same asid
  function automatic logic entry_hit(
    input logic            e_valid,
    input logic            e_global,
    input dtlb_pkg::asid_t e_asid,
    input dtlb_pkg::tag_t  e_tag,
    input dtlb_pkg::tag_t  a_tag,
    input dtlb_pkg::asid_t a_asid
  );
    return e_valid && (e_tag == a_tag) && (e_global || (e_asid == a_asid));
  endfunction

  always_ff @(posedge clk) begin
    if (wr_en) begin
      valid_q[wr_set]  <= ~wr_clear;
      global_q[wr_set] <= wr_global;
      asid_q[wr_set]   <= wr_asid;
      tag_q[wr_set]    <= wr_tag;
      ppn_q[wr_set]    <= wr_ppn;
      perm_q[wr_set]   <= wr_perm;
    end
  end

  for (genvar p = 0; p < dtlb_pkg::READ_PORTS; p++) begin : g_port
    dtlb_pkg::set_t rd_set;
    dtlb_pkg::tag_t rd_tag;

    assign rd_set = lookup_vpn[p][dtlb_pkg::SET_BITS-1:0];
    assign rd_tag = lookup_vpn[p][dtlb_pkg::VPN_BITS-1:dtlb_pkg::SET_BITS];

    assign hit[p] = entry_hit(valid_q[rd_set], global_q[rd_set], asid_q[rd_set],
                              tag_q[rd_set], rd_tag, lookup_asid[p]);
    // raw payload, zeroed on a miss further down
    assign hit_ppn[p]  = ppn_q[rd_set];
    assign hit_perm[p] = perm_q[rd_set];
  end

  // fill or invalidate address
  assign mt_set = maint_vpn[dtlb_pkg::SET_BITS-1:0];
  assign mt_tag = maint_vpn[dtlb_pkg::VPN_BITS-1:dtlb_pkg::SET_BITS];

  assign maint_hit = entry_hit(valid_q[mt_set], global_q[mt_set], asid_q[mt_set],
                               tag_q[mt_set], mt_tag, maint_asid);

endmodule

// File: dtlb_lru.sv
/*
  dtlb_lru
  per-set replacement ages for the TLB ways.
  a touched way drops to age 0 and the younger ways of its set age by one;
  the victim of a set is the way whose age is WAYS-1.
*/
`timescale 1ns/10ps
module dtlb_lru (
  input  logic           clk,
  input  logic           init_en,
  input  dtlb_pkg::set_t init_set,
  input  logic           touch_en,
  input  dtlb_pkg::set_t touch_set,
  input  dtlb_pkg::way_t touch_way,
  input  dtlb_pkg::set_t victim_set,
  output dtlb_pkg::way_t victim_way
);

  dtlb_pkg::age_t [dtlb_pkg::WAYS-1:0] age_q [dtlb_pkg::SETS];

  dtlb_pkg::age_t [dtlb_pkg::WAYS-1:0] cur_age;
  dtlb_pkg::age_t [dtlb_pkg::WAYS-1:0] new_age;
  dtlb_pkg::age_t                      touch_age;

  assign cur_age   = age_q[touch_set];
  assign touch_age = cur_age[touch_way];

  // ages after touching touch_way
  always_comb begin
    for (int w = 0; w < dtlb_pkg::WAYS; w++) begin
      if (dtlb_pkg::way_t'(w) == touch_way) begin
        new_age[w] = '0;
      end else if (cur_age[w] < touch_age) begin
        new_age[w] = cur_age[w] + dtlb_pkg::age_t'(1);
      end else begin
        new_age[w] = cur_age[w];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (init_en) begin
      age_q[init_set] <= dtlb_pkg::INIT_AGE_OF_WAY;
    end else if (touch_en) begin
      age_q[touch_set] <= new_age;
    end
  end

  // oldest way of the victim set
  always_comb begin
    victim_way = '0;
    for (int w = 0; w < dtlb_pkg::WAYS; w++) begin
      if (age_q[victim_set][w] == dtlb_pkg::age_t'(dtlb_pkg::WAYS-1)) begin
        victim_way = dtlb_pkg::way_t'(w);
      end
    end
  end

endmodule

// File: dtlb_ctrl.sv
/*
  dtlb_ctrl
  init sweep after reset and steering of fills and invalidates.
  the sweep clears one set per cycle and loads the starting ages; after it
  a fill goes to the matching way or the LRU victim, an invalidate clears
  every matching way, and a fill beats an invalidate and a port 0 touch.
*/
`timescale 1ns/10ps
module dtlb_ctrl (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          fill_en,
  input  dtlb_pkg::vpn_t                fill_vpn,
  input  logic                          inval_en,
  input  dtlb_pkg::vpn_t                inval_vpn,
  input  logic [dtlb_pkg::WAYS-1:0]     maint_hit,
  input  dtlb_pkg::way_t                victim_way,
  input  logic                          port0_lookup_hit,
  input  dtlb_pkg::way_t                port0_hit_way,
  input  dtlb_pkg::vpn_t                lookup_vpn0,
  output logic                          ready,
  output logic [dtlb_pkg::WAYS-1:0]     way_wr_en,
  output dtlb_pkg::set_t                wr_set,
  output logic                          wr_clear,
  output logic                          touch_en,
  output dtlb_pkg::set_t                touch_set,
  output dtlb_pkg::way_t                touch_way,
  output logic                          init_en
);

  dtlb_pkg::ctrl_state_t state;
  dtlb_pkg::set_t        sweep_set;

  logic                  fill_act;
  logic                  inval_act;
  dtlb_pkg::way_t        fill_way;
  dtlb_pkg::set_t        fill_set;
  dtlb_pkg::set_t        inval_set;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= dtlb_pkg::INIT;
      sweep_set <= '0;
    end else if (state == dtlb_pkg::INIT) begin
      sweep_set <= sweep_set + dtlb_pkg::set_t'(1);
      if (sweep_set == dtlb_pkg::set_t'(dtlb_pkg::SETS-1)) begin
        state <= dtlb_pkg::RUN;
      end
    end
  end

  assign ready   = (state == dtlb_pkg::RUN);
  assign init_en = (state == dtlb_pkg::INIT);

  // fill wins over invalidate
  assign fill_act  = ready & fill_en;
  assign inval_act = ready & inval_en & ~fill_en;

  assign fill_set  = fill_vpn[dtlb_pkg::SET_BITS-1:0];
  assign inval_set = inval_vpn[dtlb_pkg::SET_BITS-1:0];

  // lowest matching way, or the victim when nothing matches
  always_comb begin
    fill_way = victim_way;
    for (int w = dtlb_pkg::WAYS-1; w >= 0; w--) begin
      if (maint_hit[w]) begin
        fill_way = dtlb_pkg::way_t'(w);
      end
    end
  end

  always_comb begin
    way_wr_en = '0;
    if (init_en) begin
      way_wr_en = '1;
    end else if (fill_act) begin
      way_wr_en[fill_way] = 1'b1;
    end else if (inval_act) begin
      way_wr_en = maint_hit;
    end
  end

  assign wr_set   = init_en ? sweep_set : (fill_en ? fill_set : inval_set);
  assign wr_clear = init_en | inval_act;

  // port 0 hit touch dropped under a fill
  assign touch_en  = fill_act | port0_lookup_hit;
  assign touch_set = fill_act ? fill_set : lookup_vpn0[dtlb_pkg::SET_BITS-1:0];
  assign touch_way = fill_act ? fill_way : port0_hit_way;

endmodule

// File: dtlb_hit_select.sv
/*
  dtlb_hit_select
  merges the way hits of one lookup port into a registered response.
  the lowest hitting way supplies ppn and perm; a miss returns zeros.
*/
`timescale 1ns/10ps
module dtlb_hit_select (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  ready,
  input  logic                                  lookup_en,
  input  logic            [dtlb_pkg::WAYS-1:0]  way_hit,
  input  dtlb_pkg::ppn_t  [dtlb_pkg::WAYS-1:0]  way_ppn,
  input  dtlb_pkg::perm_t [dtlb_pkg::WAYS-1:0]  way_perm,
  output logic                                  comb_hit,
  output dtlb_pkg::way_t                        comb_way,
  output logic                                  resp_valid,
  output logic                                  resp_hit,
  output dtlb_pkg::way_t                        resp_way,
  output dtlb_pkg::ppn_t                        resp_ppn,
  output dtlb_pkg::perm_t                       resp_perm
);

  dtlb_pkg::ppn_t  sel_ppn;
  dtlb_pkg::perm_t sel_perm;

  // priority encode, lowest way first
  always_comb begin
    comb_way = '0;
    sel_ppn  = '0;
    sel_perm = '0;
    for (int w = dtlb_pkg::WAYS-1; w >= 0; w--) begin
      if (way_hit[w]) begin
        comb_way = dtlb_pkg::way_t'(w);
        sel_ppn  = way_ppn[w];
        sel_perm = way_perm[w];
      end
    end
  end

  assign comb_hit = ready & lookup_en & (|way_hit);

  always_ff @(posedge clk) begin
    if (rst) begin
      resp_valid <= 1'b0;
      resp_hit   <= 1'b0;
    end else begin
      resp_valid <= ready & lookup_en;
      resp_hit   <= comb_hit;
    end
  end

  // payload zero unless a qualified hit
  always_ff @(posedge clk) begin
    resp_way  <= comb_hit ? comb_way : '0;
    resp_ppn  <= comb_hit ? sel_ppn : '0;
    resp_perm <= comb_hit ? sel_perm : '0;
  end

endmodule

// File: dtlb.sv
/*
  dtlb
  set-associative data TLB for the load pipeline: WAYS ways of SETS sets,
  READ_PORTS lookup ports with a one-cycle registered response, plus a
  fill and an invalidate path with age-based replacement.
*/
`timescale 1ns/10ps
module dtlb (
  input  logic                                          clk,
  input  logic                                          rst,
  input  logic            [dtlb_pkg::READ_PORTS-1:0]    lookup_en,
  input  dtlb_pkg::vpn_t  [dtlb_pkg::READ_PORTS-1:0]    lookup_vpn,
  input  dtlb_pkg::asid_t [dtlb_pkg::READ_PORTS-1:0]    lookup_asid,
  input  logic                                          fill_en,
  input  dtlb_pkg::vpn_t                                fill_vpn,
  input  dtlb_pkg::asid_t                               fill_asid,
  input  logic                                          fill_global,
  input  dtlb_pkg::ppn_t                                fill_ppn,
  input  dtlb_pkg::perm_t                               fill_perm,
  input  logic                                          inval_en,
  input  dtlb_pkg::vpn_t                                inval_vpn,
  input  dtlb_pkg::asid_t                               inval_asid,
  output logic                                          ready,
  output logic            [dtlb_pkg::READ_PORTS-1:0]    resp_valid,
  output logic            [dtlb_pkg::READ_PORTS-1:0]    resp_hit,
  output dtlb_pkg::way_t  [dtlb_pkg::READ_PORTS-1:0]    resp_way,
  output dtlb_pkg::ppn_t  [dtlb_pkg::READ_PORTS-1:0]    resp_ppn,
  output dtlb_pkg::perm_t [dtlb_pkg::READ_PORTS-1:0]    resp_perm
);

  // way side, indexed [way][port]
  logic            [dtlb_pkg::WAYS-1:0][dtlb_pkg::READ_PORTS-1:0] way_hit;
  dtlb_pkg::ppn_t  [dtlb_pkg::WAYS-1:0][dtlb_pkg::READ_PORTS-1:0] way_ppn;
  dtlb_pkg::perm_t [dtlb_pkg::WAYS-1:0][dtlb_pkg::READ_PORTS-1:0] way_perm;

  // port side, indexed [port][way]
  logic            [dtlb_pkg::READ_PORTS-1:0][dtlb_pkg::WAYS-1:0] port_hit;
  dtlb_pkg::ppn_t  [dtlb_pkg::READ_PORTS-1:0][dtlb_pkg::WAYS-1:0] port_ppn;
  dtlb_pkg::perm_t [dtlb_pkg::READ_PORTS-1:0][dtlb_pkg::WAYS-1:0] port_perm;

  logic            [dtlb_pkg::READ_PORTS-1:0] comb_hit;
  dtlb_pkg::way_t  [dtlb_pkg::READ_PORTS-1:0] comb_way;

  logic            [dtlb_pkg::WAYS-1:0]       maint_hit;
  logic            [dtlb_pkg::WAYS-1:0]       way_wr_en;
  dtlb_pkg::vpn_t                             maint_vpn;
  dtlb_pkg::asid_t                            maint_asid;
  dtlb_pkg::tag_t                             fill_tag;
  dtlb_pkg::set_t                             fill_set;
  dtlb_pkg::set_t                             wr_set;
  logic                                       wr_clear;
  logic                                       init_en;
  logic                                       touch_en;
  dtlb_pkg::set_t                             touch_set;
  dtlb_pkg::way_t                             touch_way;
  dtlb_pkg::way_t                             victim_way;

  // fill address has priority on the maintenance compare
  assign maint_vpn  = fill_en ? fill_vpn : inval_vpn;
  assign maint_asid = fill_en ? fill_asid : inval_asid;

  assign fill_tag = fill_vpn[dtlb_pkg::VPN_BITS-1:dtlb_pkg::SET_BITS];
  assign fill_set = fill_vpn[dtlb_pkg::SET_BITS-1:0];

  for (genvar w = 0; w < dtlb_pkg::WAYS; w++) begin : g_way
    dtlb_way u_way (
      .clk         (clk),
      .wr_en       (way_wr_en[w]),
      .wr_set      (wr_set),
      .wr_clear    (wr_clear),
      .wr_tag      (fill_tag),
      .wr_asid     (fill_asid),
      .wr_global   (fill_global),
      .wr_ppn      (fill_ppn),
      .wr_perm     (fill_perm),
      .lookup_vpn  (lookup_vpn),
      .lookup_asid (lookup_asid),
      .maint_vpn   (maint_vpn),
      .maint_asid  (maint_asid),
      .hit         (way_hit[w]),
      .hit_ppn     (way_ppn[w]),
      .hit_perm    (way_perm[w]),
      .maint_hit   (maint_hit[w])
    );

    for (genvar p = 0; p < dtlb_pkg::READ_PORTS; p++) begin : g_xpose
      assign port_hit[p][w]  = way_hit[w][p];
      assign port_ppn[p][w]  = way_ppn[w][p];
      assign port_perm[p][w] = way_perm[w][p];
    end
  end

  dtlb_lru u_lru (
    .clk        (clk),
    .init_en    (init_en),
    .init_set   (wr_set),
    .touch_en   (touch_en),
    .touch_set  (touch_set),
    .touch_way  (touch_way),
    .victim_set (fill_set),
    .victim_way (victim_way)
  );

  dtlb_ctrl u_ctrl (
    .clk              (clk),
    .rst              (rst),
    .fill_en          (fill_en),
    .fill_vpn         (fill_vpn),
    .inval_en         (inval_en),
    .inval_vpn        (inval_vpn),
    .maint_hit        (maint_hit),
    .victim_way       (victim_way),
    .port0_lookup_hit (comb_hit[0]),
    .port0_hit_way    (comb_way[0]),
    .lookup_vpn0      (lookup_vpn[0]),
    .ready            (ready),
    .way_wr_en        (way_wr_en),
    .wr_set           (wr_set),
    .wr_clear         (wr_clear),
    .touch_en         (touch_en),
    .touch_set        (touch_set),
    .touch_way        (touch_way),
    .init_en          (init_en)
  );

  for (genvar p = 0; p < dtlb_pkg::READ_PORTS; p++) begin : g_resp
    dtlb_hit_select u_hit_select (
      .clk        (clk),
      .rst        (rst),
      .ready      (ready),
      .lookup_en  (lookup_en[p]),
      .way_hit    (port_hit[p]),
      .way_ppn    (port_ppn[p]),
      .way_perm   (port_perm[p]),
      .comb_hit   (comb_hit[p]),
      .comb_way   (comb_way[p]),
      .resp_valid (resp_valid[p]),
      .resp_hit   (resp_hit[p]),
      .resp_way   (resp_way[p]),
      .resp_ppn   (resp_ppn[p]),
      .resp_perm  (resp_perm[p])
    );
  end

endmodule

// File: dtlb_checker.sv
/*
  dtlb_checker
  concurrent assertions on the TLB top-level ports: response strobe
  timing, hit qualification, ready stability and zero payload on a miss.
*/
`timescale 1ns/10ps
module dtlb_checker (
  input logic                                        clk,
  input logic                                        rst,
  input logic                                        ready,
  input logic           [dtlb_pkg::READ_PORTS-1:0]   lookup_en,
  input logic           [dtlb_pkg::READ_PORTS-1:0]   resp_valid,
  input logic           [dtlb_pkg::READ_PORTS-1:0]   resp_hit,
  input dtlb_pkg::ppn_t [dtlb_pkg::READ_PORTS-1:0]   resp_ppn
);

  for (genvar p = 0; p < dtlb_pkg::READ_PORTS; p++) begin : g_port
    // strobe exactly one cycle after a qualified lookup
    a_valid_timing: assert property (@(posedge clk) disable iff (rst)
      resp_valid[p] == $past(lookup_en[p] & ready))
      else $error("resp_valid timing wrong on port %0d", p);

    a_hit_needs_valid: assert property (@(posedge clk) disable iff (rst)
      resp_hit[p] |-> resp_valid[p])
      else $error("resp_hit without resp_valid on port %0d", p);

    a_miss_zero_ppn: assert property (@(posedge clk) disable iff (rst)
      (resp_valid[p] && !resp_hit[p]) |-> (resp_ppn[p] == '0))
      else $error("nonzero resp_ppn on a miss on port %0d", p);
  end

  a_ready_stable: assert property (@(posedge clk) disable iff (rst) !$fell(ready))
    else $error("ready fell outside reset");

endmodule

// File: dtlb_tb.sv
/*
  dtlb testbench
  directed and random stimulus for the data TLB, with a reference model
  of entries and replacement ages that predicts every response.
*/
`timescale 1ns/10ps
module dtlb_tb;

  logic clk, rst, fill_en, fill_global, inval_en, ready;
  logic [dtlb_pkg::READ_PORTS-1:0] lookup_en, resp_valid, resp_hit;
  dtlb_pkg::vpn_t [dtlb_pkg::READ_PORTS-1:0] lookup_vpn;
  dtlb_pkg::asid_t [dtlb_pkg::READ_PORTS-1:0] lookup_asid;
  dtlb_pkg::vpn_t fill_vpn, inval_vpn;
  dtlb_pkg::asid_t fill_asid, inval_asid;
  dtlb_pkg::ppn_t fill_ppn;
  dtlb_pkg::perm_t fill_perm;
  dtlb_pkg::way_t [dtlb_pkg::READ_PORTS-1:0] resp_way;
  dtlb_pkg::ppn_t [dtlb_pkg::READ_PORTS-1:0] resp_ppn;
  dtlb_pkg::perm_t [dtlb_pkg::READ_PORTS-1:0] resp_perm;

  // values applied at the next rising edge
  logic nx_rst, nx_fill_en, nx_fill_global, nx_inval_en;
  logic [dtlb_pkg::READ_PORTS-1:0] nx_lookup_en;
  dtlb_pkg::vpn_t [dtlb_pkg::READ_PORTS-1:0] nx_lookup_vpn;
  dtlb_pkg::asid_t [dtlb_pkg::READ_PORTS-1:0] nx_lookup_asid;
  dtlb_pkg::vpn_t nx_fill_vpn, nx_inval_vpn;
  dtlb_pkg::asid_t nx_fill_asid, nx_inval_asid;
  dtlb_pkg::ppn_t nx_fill_ppn;
  dtlb_pkg::perm_t nx_fill_perm;

  // reference model
  logic m_valid [dtlb_pkg::WAYS][dtlb_pkg::SETS];
  logic m_global [dtlb_pkg::WAYS][dtlb_pkg::SETS];
  dtlb_pkg::asid_t m_asid [dtlb_pkg::WAYS][dtlb_pkg::SETS];
  dtlb_pkg::tag_t m_tag [dtlb_pkg::WAYS][dtlb_pkg::SETS];
  dtlb_pkg::ppn_t m_ppn [dtlb_pkg::WAYS][dtlb_pkg::SETS];
  dtlb_pkg::perm_t m_perm [dtlb_pkg::WAYS][dtlb_pkg::SETS];
  int m_age [dtlb_pkg::SETS][dtlb_pkg::WAYS];
  logic model_ready;
  int init_cnt;
  logic [dtlb_pkg::READ_PORTS-1:0] exp_valid, exp_hit;
  int exp_way [dtlb_pkg::READ_PORTS];
  dtlb_pkg::ppn_t exp_ppn [dtlb_pkg::READ_PORTS];
  dtlb_pkg::perm_t exp_perm [dtlb_pkg::READ_PORTS];

  logic [31:0] lfsr = 32'ha6ed_6d8f;
  int cnt;

  dtlb u_dtlb (.*);

  bind dtlb dtlb_checker u_checker (
    .clk(clk), .rst(rst), .ready(ready), .lookup_en(lookup_en),
    .resp_valid(resp_valid), .resp_hit(resp_hit), .resp_ppn(resp_ppn)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // one LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
      $display("Errors found");
      $fatal(1, "mismatch");
    end
  endtask

  function automatic dtlb_pkg::vpn_t mk_vpn(input logic [15:0] tag, input logic [3:0] set);
    return {tag, set};
  endfunction

  // lowest way whose entry matches, or -1
  function automatic int find_way(input dtlb_pkg::vpn_t v, input dtlb_pkg::asid_t a);
    int s;
    s = int'(v[3:0]);
    for (int w = 0; w < dtlb_pkg::WAYS; w++) begin
      if (m_valid[w][s] && m_tag[w][s] == v[19:4] && (m_global[w][s] || m_asid[w][s] == a)) begin
        return w;
      end
    end
    return -1;
  endfunction

  task automatic touch(input int s, input int tw);
    int ta;
    ta = m_age[s][tw];
    for (int w = 0; w < dtlb_pkg::WAYS; w++) begin
      if (w == tw) m_age[s][w] = 0;
      else if (m_age[s][w] < ta) m_age[s][w] = m_age[s][w] + 1;
    end
  endtask

  // evaluates the inputs sampled at this edge
  task automatic model_edge();
    int w, s, p0w;
    p0w = -1;
    exp_valid = '0;
    exp_hit = '0;
    if (rst) begin
      model_ready = 1'b0;
      init_cnt = 0;
    end else if (!model_ready) begin
      for (int k = 0; k < dtlb_pkg::WAYS; k++) begin
        m_valid[k][init_cnt] = 1'b0;
        m_age[init_cnt][k] = k;
      end
      init_cnt++;
      if (init_cnt == dtlb_pkg::SETS) model_ready = 1'b1;
    end else begin
      for (int p = 0; p < dtlb_pkg::READ_PORTS; p++) begin
        w = find_way(lookup_vpn[p], lookup_asid[p]);
        exp_valid[p] = lookup_en[p];
        exp_hit[p] = lookup_en[p] && (w >= 0);
        exp_way[p] = exp_hit[p] ? w : 0;
        exp_ppn[p] = exp_hit[p] ? m_ppn[w][lookup_vpn[p][3:0]] : '0;
        exp_perm[p] = exp_hit[p] ? m_perm[w][lookup_vpn[p][3:0]] : '0;
        if (p == 0 && exp_hit[0]) p0w = w;
      end
      if (fill_en) begin
        s = int'(fill_vpn[3:0]);
        w = find_way(fill_vpn, fill_asid);
        if (w < 0) begin
          for (int k = 0; k < dtlb_pkg::WAYS; k++) begin
            if (m_age[s][k] == dtlb_pkg::WAYS - 1) w = k;
          end
        end
        m_valid[w][s] = 1'b1;
        m_global[w][s] = fill_global;
        m_asid[w][s] = fill_asid;
        m_tag[w][s] = fill_vpn[19:4];
        m_ppn[w][s] = fill_ppn;
        m_perm[w][s] = fill_perm;
        touch(s, w);
      end else begin
        if (inval_en) begin
          // clear every matching way of the set
          s = int'(inval_vpn[3:0]);
          for (int k = dtlb_pkg::WAYS - 1; k >= 0; k--) begin
            if (m_valid[k][s] && m_tag[k][s] == inval_vpn[19:4] &&
                (m_global[k][s] || m_asid[k][s] == inval_asid)) m_valid[k][s] = 1'b0;
          end
        end
        if (p0w >= 0) touch(int'(lookup_vpn[0][3:0]), p0w);
      end
    end
  endtask

  task automatic check_outputs();
    check("ready", 32'(ready), 32'(model_ready));
    for (int p = 0; p < dtlb_pkg::READ_PORTS; p++) begin
      check($sformatf("resp_valid[%0d]", p), 32'(resp_valid[p]), 32'(exp_valid[p]));
      check($sformatf("resp_hit[%0d]", p), 32'(resp_hit[p]), 32'(exp_hit[p]));
      if (exp_valid[p]) begin
        check($sformatf("resp_way[%0d]", p), 32'(resp_way[p]), 32'(exp_way[p]));
        check($sformatf("resp_ppn[%0d]", p), 32'(resp_ppn[p]), 32'(exp_ppn[p]));
        check($sformatf("resp_perm[%0d]", p), 32'(resp_perm[p]), 32'(exp_perm[p]));
      end
    end
  endtask

  task automatic cycle();
    @(posedge clk);
    model_edge();
    rst <= nx_rst;
    lookup_en <= nx_lookup_en;
    lookup_vpn <= nx_lookup_vpn;
    lookup_asid <= nx_lookup_asid;
    fill_en <= nx_fill_en;
    fill_vpn <= nx_fill_vpn;
    fill_asid <= nx_fill_asid;
    fill_global <= nx_fill_global;
    fill_ppn <= nx_fill_ppn;
    fill_perm <= nx_fill_perm;
    inval_en <= nx_inval_en;
    inval_vpn <= nx_inval_vpn;
    inval_asid <= nx_inval_asid;
    nx_lookup_en = '0;
    nx_fill_en = 1'b0;
    nx_inval_en = 1'b0;
    @(negedge clk);
    check_outputs();
  endtask

  task automatic set_lookup(input int p, input dtlb_pkg::vpn_t v, input dtlb_pkg::asid_t a);
    nx_lookup_en[p] = 1'b1;
    nx_lookup_vpn[p] = v;
    nx_lookup_asid[p] = a;
  endtask

  task automatic set_fill(input dtlb_pkg::vpn_t v, input dtlb_pkg::asid_t a, input logic g,
                          input dtlb_pkg::ppn_t pp, input dtlb_pkg::perm_t pm);
    nx_fill_en = 1'b1;
    nx_fill_vpn = v;
    nx_fill_asid = a;
    nx_fill_global = g;
    nx_fill_ppn = pp;
    nx_fill_perm = pm;
  endtask

  task automatic set_inval(input dtlb_pkg::vpn_t v, input dtlb_pkg::asid_t a);
    nx_inval_en = 1'b1;
    nx_inval_vpn = v;
    nx_inval_asid = a;
  endtask

  // directed hit or miss check with a zero payload on a miss
  task automatic expect_resp(input int p, input logic h);
    check($sformatf("resp_hit[%0d]", p), 32'(resp_hit[p]), 32'(h));
    if (!h) begin
      check($sformatf("resp_way[%0d]", p), 32'(resp_way[p]), 32'd0);
      check($sformatf("resp_ppn[%0d]", p), 32'(resp_ppn[p]), 32'd0);
      check($sformatf("resp_perm[%0d]", p), 32'(resp_perm[p]), 32'd0);
    end
  endtask

  initial begin
    rst = 1'b1;
    lookup_en = '0;
    lookup_vpn = '0;
    lookup_asid = '0;
    fill_en = 1'b0;
    fill_vpn = '0;
    fill_asid = '0;
    fill_global = 1'b0;
    fill_ppn = '0;
    fill_perm = '0;
    inval_en = 1'b0;
    inval_vpn = '0;
    inval_asid = '0;
    nx_rst = 1'b1;
    nx_lookup_en = '0;
    nx_lookup_vpn = '0;
    nx_lookup_asid = '0;
    nx_fill_en = 1'b0;
    nx_fill_vpn = '0;
    nx_fill_asid = '0;
    nx_fill_global = 1'b0;
    nx_fill_ppn = '0;
    nx_fill_perm = '0;
    nx_inval_en = 1'b0;
    nx_inval_vpn = '0;
    nx_inval_asid = '0;
    model_ready = 1'b0;
    init_cnt = 0;
    exp_valid = '0;
    exp_hit = '0;

    repeat (15) cycle();
    nx_rst = 1'b0;
    cycle();
    // init sweep length
    cnt = 0;
    while (!ready) begin
      cycle();
      cnt++;
      if (cnt > dtlb_pkg::SETS + 8) begin
        $display("timeout waiting for ready after reset");
        $display("Errors found");
        $fatal(1, "timeout");
      end
    end
    check("sweep cycles", 32'(cnt), 32'(dtlb_pkg::SETS));

    // empty TLB misses on both ports
    set_lookup(0, mk_vpn(16'h1234, 4'd1), 8'd1);
    set_lookup(1, mk_vpn(16'h5678, 4'd2), 8'd1);
    cycle();
    cycle();
    expect_resp(0, 1'b0);
    expect_resp(1, 1'b0);

    // fill not seen by a lookup in the same cycle, seen after
    set_fill(mk_vpn(16'h00a1, 4'd3), 8'd3, 1'b0, 20'h12345, 4'h5);
    set_lookup(0, mk_vpn(16'h00a1, 4'd3), 8'd3);
    cycle();
    cycle();
    expect_resp(0, 1'b0);
    set_lookup(0, mk_vpn(16'h00a1, 4'd3), 8'd3);
    set_lookup(1, mk_vpn(16'h00a1, 4'd3), 8'd3);
    cycle();
    cycle();
    expect_resp(0, 1'b1);
    expect_resp(1, 1'b1);

    // asid mismatch misses, global entry hits any asid
    set_fill(mk_vpn(16'h00b2, 4'd3), 8'd3, 1'b1, 20'h0beef, 4'h3);
    set_lookup(0, mk_vpn(16'h00a1, 4'd3), 8'd4);
    cycle();
    cycle();
    expect_resp(0, 1'b0);
    set_lookup(1, mk_vpn(16'h00b2, 4'd3), 8'd9);
    cycle();
    cycle();
    expect_resp(1, 1'b1);

    // overflow one set with port 0 hits in between, then refill
    for (int i = 0; i < 7; i++) begin
      set_fill(mk_vpn(16'h0c00 + 16'(i), 4'd5), 8'd2, 1'b0, 20'(i + 16), 4'(i));
      set_lookup(0, mk_vpn(16'h0c00 + 16'(i / 3), 4'd5), 8'd2);
      cycle();
      set_lookup(0, mk_vpn(16'h0c00 + 16'(i / 2), 4'd5), 8'd2);
      cycle();
    end
    set_fill(mk_vpn(16'h0c06, 4'd5), 8'd2, 1'b0, 20'hfffff, 4'hf);
    cycle();
    for (int i = 0; i < 7; i++) begin
      set_lookup(1, mk_vpn(16'h0c00 + 16'(i), 4'd5), 8'd2);
      cycle();
    end

    // invalidate one entry, another of the set stays
    set_inval(mk_vpn(16'h0c06, 4'd5), 8'd2);
    cycle();
    set_lookup(0, mk_vpn(16'h0c06, 4'd5), 8'd2);
    set_lookup(1, mk_vpn(16'h0c05, 4'd5), 8'd2);
    cycle();
    cycle();
    expect_resp(0, 1'b0);
    expect_resp(1, 1'b1);

    // fill beating an invalidate
    set_fill(mk_vpn(16'h0d01, 4'd7), 8'd1, 1'b0, 20'h00777, 4'h7);
    cycle();
    set_fill(mk_vpn(16'h0d02, 4'd7), 8'd1, 1'b0, 20'h00778, 4'h8);
    set_inval(mk_vpn(16'h0d01, 4'd7), 8'd1);
    cycle();
    set_lookup(0, mk_vpn(16'h0d01, 4'd7), 8'd1);
    set_lookup(1, mk_vpn(16'h0d02, 4'd7), 8'd1);
    cycle();
    cycle();
    expect_resp(0, 1'b1);
    expect_resp(1, 1'b1);

    // random mix over a small address pool
    for (int n = 0; n < 4000; n++) begin
      for (int p = 0; p < dtlb_pkg::READ_PORTS; p++) begin
        if (rand_bits(1) != 0) begin
          set_lookup(p, mk_vpn(16'ha000 | 16'(rand_bits(3)), 4'(rand_bits(2))),
                     8'(rand_bits(1)) + 8'd1);
        end
      end
      if (rand_bits(2) == 0) begin
        set_fill(mk_vpn(16'ha000 | 16'(rand_bits(3)), 4'(rand_bits(2))),
                 8'(rand_bits(1)) + 8'd1, rand_bits(3) == 0, 20'(rand_bits(20)),
                 4'(rand_bits(4)));
      end
      if (rand_bits(3) == 0) begin
        set_inval(mk_vpn(16'ha000 | 16'(rand_bits(3)), 4'(rand_bits(2))),
                  8'(rand_bits(1)) + 8'd1);
      end
      cycle();
    end
    cycle();
    cycle();
    $display("No errors");
    $finish;
  end

endmodule

// File: dtlb.f
dtlb_pkg.sv
dtlb_way.sv
dtlb_lru.sv
dtlb_ctrl.sv
dtlb_hit_select.sv
dtlb.sv
dtlb_checker.sv
dtlb_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the dtlb testbench with Verilator
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module dtlb_tb \
    -f dtlb.f -o dtlb_sim &&
  ./obj_dir/dtlb_sim || exit 1
